// File: design/hps_pkg.sv
// host command bridge shared definitions
// command codes, bus word types and PS/2 special sequences
package hps_pkg;

	////////////////////////////////
	// bus words and payload types
	////////////////////////////////
	typedef logic [15:0] word_t;

	localparam int WORD_IDX_W = 4;
	typedef logic [WORD_IDX_W-1:0] word_idx_t;

	localparam int NUM_JOY   = 6;
	localparam int JOY_IDX_W = $clog2(NUM_JOY);
	typedef logic [31:0] joy_t;

	typedef logic [63:0] status_t;

	// [10] toggles per event, [9] pressed, [8] extended, [7:0] code
	typedef logic [10:0] ps2_key_t;

	localparam int IOCTL_ADDR_W = 27;

	////////////////////////////////
	// io channel commands
	////////////////////////////////
	localparam word_t CMD_CFG        = 16'h0001;
	localparam word_t CMD_JOY0       = 16'h0002;
	localparam word_t CMD_JOY1       = 16'h0003;
	localparam word_t CMD_KBD        = 16'h0005;
	localparam word_t CMD_JOY2       = 16'h0010;
	localparam word_t CMD_JOY3       = 16'h0011;
	localparam word_t CMD_JOY4       = 16'h0012;
	localparam word_t CMD_JOY5       = 16'h0013;
	localparam word_t CMD_STATUS     = 16'h001E;
	localparam word_t CMD_STATUS_REQ = 16'h0029;
	localparam word_t CMD_MENUMASK   = 16'h002E;

	// file channel commands
	localparam word_t CMD_FILE_TX    = 16'h0053;
	localparam word_t CMD_FILE_DAT   = 16'h0054;
	localparam word_t CMD_FILE_INDEX = 16'h0055;
	localparam word_t CMD_FILE_INFO  = 16'h0056;

	localparam logic [3:0] STATUS_REQ_TAG = 4'hA;

	// configuration word bit positions
	localparam logic [3:0] CFG_FORCED_SD_BIT    = 4'd4;
	localparam logic [3:0] CFG_DIRECT_VIDEO_BIT = 4'd10;

	////////////////////////////////
	// PS/2 scan code bytes
	////////////////////////////////
	localparam logic [7:0] PS2_EXT_PREFIX   = 8'hE0;
	localparam logic [7:0] PS2_BREAK_PREFIX = 8'hF0;

	// multi byte keys that get a fixed event code
	localparam logic [31:0] KEY_PRNSCR_MAKE  = 32'hE012E07C;
	localparam logic [31:0] KEY_PRNSCR_BREAK = 32'h7CE0F012;
	localparam logic [31:0] KEY_PAUSE_MAKE   = 32'hF014F077;

	localparam logic [9:0] KEY_PRNSCR_MAKE_CODE  = 10'h37C;
	localparam logic [9:0] KEY_PRNSCR_BREAK_CODE = 10'h17C;
	localparam logic [9:0] KEY_PAUSE_MAKE_CODE   = 10'h377;

endpackage

// File: design/host_frame_if.sv
// one decoded host command frame
// driven by the framer, read by the command handlers
`timescale 1ns/1ps

interface host_frame_if;
	import hps_pkg::*;

	logic      cmd_pulse;
	logic      data_pulse;
	word_t     word;
	word_t     cmd;
	word_idx_t idx;
	logic      frame_end;

	modport framer (
		output cmd_pulse, data_pulse, word, cmd, idx, frame_end
	);

	modport handler (
		input cmd_pulse, data_pulse, word, cmd, idx, frame_end
	);

endinterface

// File: design/host_frame_decoder.sv
// host bus framer
// splits an enable-framed strobe stream into command and data words,
// counts words in the frame and flags the end of a framed command
`timescale 1ns/1ps

module host_frame_decoder (
	input  logic           clk_sys,
	input  logic           reset,
	input  logic           enable,
	input  logic           strobe,
	input  hps_pkg::word_t word,
	host_frame_if.framer   frame
);

	// set once the command word of the current frame is in
	logic has_cmd;

	// first strobe of a frame is the command, the rest are data
	assign frame.cmd_pulse  = enable & strobe & ~has_cmd;
	assign frame.data_pulse = enable & strobe & has_cmd;
	assign frame.word       = word;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			has_cmd         <= 1'b0;
			frame.idx       <= '0;
			frame.frame_end <= 1'b0;
		end else begin
			frame.frame_end <= ~enable & has_cmd;

			if (~enable) begin
				has_cmd   <= 1'b0;
				frame.idx <= '0;
			end else if (strobe) begin
				has_cmd <= 1'b1;
				// saturate so long frames keep the last index
				if (~&frame.idx) begin
					frame.idx <= frame.idx + 1'b1;
				end
			end
		end
	end

	// command stays valid through the frame_end cycle for the handlers
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			frame.cmd <= '0;
		end else if (frame.cmd_pulse) begin
			frame.cmd <= word;
		end else if (frame.frame_end) begin
			frame.cmd <= '0;
		end
	end

	// the host leaves an idle cycle after every word of a frame
	assert property (@(posedge clk_sys) disable iff (reset)
		(frame.cmd_pulse || frame.data_pulse) |=> !(frame.cmd_pulse || frame.data_pulse));

endmodule

// File: design/control_regs.sv
// core control registers on the io channel
// configuration word, digital joysticks, 64-bit status,
// status request readback and menu mask reply
`timescale 1ns/1ps

module control_regs (
	input  logic             clk_sys,
	input  logic             reset,
	host_frame_if.handler    frame,
	input  hps_pkg::status_t status_in,
	input  logic             status_set,
	input  hps_pkg::word_t   status_menumask,
	output hps_pkg::word_t   cfg,
	output hps_pkg::joy_t    joystick [hps_pkg::NUM_JOY],
	output hps_pkg::status_t status,
	output hps_pkg::word_t   io_dout
);
	import hps_pkg::*;

	logic                 old_status_set;
	logic [3:0]           req_cnt;
	status_t              status_req;
	logic                 joy_hit;
	logic [JOY_IDX_W-1:0] joy_sel;
	logic                 dout_idle;

	// joystick command to array slot
	always_comb begin
		joy_hit = 1'b1;
		joy_sel = '0;
		case (frame.cmd)
			CMD_JOY0: joy_sel = JOY_IDX_W'(0);
			CMD_JOY1: joy_sel = JOY_IDX_W'(1);
			CMD_JOY2: joy_sel = JOY_IDX_W'(2);
			CMD_JOY3: joy_sel = JOY_IDX_W'(3);
			CMD_JOY4: joy_sel = JOY_IDX_W'(4);
			CMD_JOY5: joy_sel = JOY_IDX_W'(5);
			default:  joy_hit = 1'b0;
		endcase
	end

	//////////////////////////////
	// core status request
	//////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_status_set <= 1'b0;
			req_cnt        <= '0;
			status_req     <= '0;
		end else begin
			old_status_set <= status_set;
			if (status_set && !old_status_set) begin
				req_cnt    <= req_cnt + 4'd1;
				status_req <= status_in;
			end
		end
	end

	//////////////////////////////
	// host register writes
	//////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cfg    <= '0;
			status <= '0;
			for (int i = 0; i < NUM_JOY; i++) begin
				joystick[i] <= '0;
			end
		end else if (frame.data_pulse) begin
			if (frame.cmd == CMD_CFG && frame.idx == word_idx_t'(1)) begin
				cfg <= frame.word;
			end

			// first data word is the low half, anything later the high half
			if (joy_hit) begin
				if (frame.idx == word_idx_t'(1)) begin
					joystick[joy_sel][15:0] <= frame.word;
				end else begin
					joystick[joy_sel][31:16] <= frame.word;
				end
			end

			if (frame.cmd == CMD_STATUS) begin
				case (frame.idx)
					word_idx_t'(1): status[15:0]  <= frame.word;
					word_idx_t'(2): status[31:16] <= frame.word;
					word_idx_t'(3): status[47:32] <= frame.word;
					word_idx_t'(4): status[63:48] <= frame.word;
					default: ;
				endcase
			end
		end
	end

	//////////////////////////////
	// reply word
	//////////////////////////////
	// a strobe prepares the word the host reads before its next strobe
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_dout <= '0;
		end else if (frame.cmd_pulse) begin
			case (frame.word)
				CMD_STATUS_REQ: io_dout <= word_t'({STATUS_REQ_TAG, req_cnt});
				CMD_MENUMASK:   io_dout <= status_menumask;
				default:        io_dout <= '0;
			endcase
		end else if (frame.data_pulse) begin
			io_dout <= '0;
			if (frame.cmd == CMD_STATUS_REQ) begin
				case (frame.idx)
					word_idx_t'(1): io_dout <= status_req[31:16];
					word_idx_t'(2): io_dout <= status_req[47:32];
					word_idx_t'(3): io_dout <= status_req[63:48];
					default: ;
				endcase
			end
		end else if (frame.frame_end) begin
			io_dout <= '0;
		end
	end

	// no pulse seen since the last frame end
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dout_idle <= 1'b1;
		end else if (frame.cmd_pulse || frame.data_pulse) begin
			dout_idle <= 1'b0;
		end else if (frame.frame_end) begin
			dout_idle <= 1'b1;
		end
	end

	// between frames the host must read back zero
	assert property (@(posedge clk_sys) disable iff (reset)
		dout_idle |-> io_dout == '0);

endmodule

// File: design/ps2_key_decoder.sv
// PS/2 keyboard alternative interface
// gathers scan code bytes of a keyboard frame and
// turns them into one key event word when the frame closes
`timescale 1ns/1ps

module ps2_key_decoder (
	input  logic              clk_sys,
	input  logic              reset,
	host_frame_if.handler     frame,
	output hps_pkg::ps2_key_t ps2_key
);
	import hps_pkg::*;

	logic [31:0] key_raw;
	logic        skip;
	logic        kbd_frame;
	logic        pressed;
	logic        extended;
	logic [9:0]  key_event;

	assign kbd_frame = (frame.cmd == CMD_KBD);

	// a break code puts F0 right in front of the key byte
	assign pressed  = (key_raw[15:8] != PS2_BREAK_PREFIX);
	assign extended = pressed ? (key_raw[15:8] == PS2_EXT_PREFIX) :
		(key_raw[23:16] == PS2_EXT_PREFIX);

	always_comb begin
		case (key_raw)
			KEY_PRNSCR_MAKE:  key_event = KEY_PRNSCR_MAKE_CODE;
			KEY_PRNSCR_BREAK: key_event = KEY_PRNSCR_BREAK_CODE;
			KEY_PAUSE_MAKE:   key_event = KEY_PAUSE_MAKE_CODE;
			default:          key_event = {pressed, extended, key_raw[7:0]};
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			key_raw <= '0;
			skip    <= 1'b0;
			ps2_key <= '0;
		end else begin
			if (frame.cmd_pulse && frame.word == CMD_KBD) begin
				key_raw <= '0;
			end else if (frame.data_pulse && kbd_frame) begin
				// upper byte all ones means the frame carries no key
				if (&frame.word[15:8]) begin
					skip <= 1'b1;
				end else if (!skip) begin
					key_raw <= {key_raw[23:0], frame.word[7:0]};
				end
			end

			if (frame.frame_end) begin
				skip <= 1'b0;
				if (kbd_frame && !skip) begin
					ps2_key <= {~ps2_key[10], key_event};
				end
			end
		end
	end

endmodule

// File: design/file_loader.sv
// file download channel
// takes index, file extension, start/stop and data bytes from the
// host and writes them out with an auto-incremented byte address
`timescale 1ns/1ps

module file_loader (
	input  logic                             clk_sys,
	input  logic                             reset,
	host_frame_if.handler                    frame,
	output logic                             ioctl_download,
	output logic [7:0]                       ioctl_index,
	output logic                             ioctl_wr,
	output logic [hps_pkg::IOCTL_ADDR_W-1:0] ioctl_addr,
	output logic [7:0]                       ioctl_dout,
	output logic [31:0]                      ioctl_file_ext
);
	import hps_pkg::*;

	// next byte address
	logic [IOCTL_ADDR_W-1:0] addr;
	logic                    wr_pend;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ioctl_download <= 1'b0;
			ioctl_index    <= '0;
			ioctl_wr       <= 1'b0;
			ioctl_addr     <= '0;
			ioctl_dout     <= '0;
			ioctl_file_ext <= '0;
			addr           <= '0;
			wr_pend        <= 1'b0;
		end else begin
			// write strobe lags the data load by one cycle
			ioctl_wr <= wr_pend;
			wr_pend  <= 1'b0;

			if (frame.data_pulse) begin
				case (frame.cmd)
					CMD_FILE_INFO: begin
						if (frame.idx == word_idx_t'(1)) begin
							ioctl_file_ext[31:16] <= frame.word;
						end else if (frame.idx == word_idx_t'(2)) begin
							ioctl_file_ext[15:0] <= frame.word;
						end
					end

					CMD_FILE_INDEX: ioctl_index <= frame.word[7:0];

					// nonzero starts a download, zero ends it
					CMD_FILE_TX: begin
						if (|frame.word[7:0]) begin
							addr           <= '0;
							ioctl_download <= 1'b1;
						end else begin
							ioctl_addr     <= addr;
							ioctl_download <= 1'b0;
						end
					end

					CMD_FILE_DAT: begin
						ioctl_addr <= addr;
						ioctl_dout <= frame.word[7:0];
						wr_pend    <= 1'b1;
						addr       <= addr + IOCTL_ADDR_W'(1);
					end

					default: ;
				endcase
			end
		end
	end

	// one write pulse per data strobe
	assert property (@(posedge clk_sys) disable iff (reset)
		ioctl_wr |=> !ioctl_wr);

endmodule

// File: design/hps_io.sv
// host command bridge top level
// one framer per enable feeds the control, keyboard and download handlers
`timescale 1ns/1ps

module hps_io (
	input  logic                             clk_sys,
	input  logic                             reset,
	input  logic                             io_enable,
	input  logic                             fp_enable,
	input  logic                             io_strobe,
	input  hps_pkg::word_t                   io_din,
	output hps_pkg::word_t                   io_dout,
	output logic [1:0]                       buttons,
	output logic                             forced_scandoubler,
	output logic                             direct_video,
	output hps_pkg::joy_t                    joystick_0,
	output hps_pkg::joy_t                    joystick_1,
	output hps_pkg::joy_t                    joystick_2,
	output hps_pkg::joy_t                    joystick_3,
	output hps_pkg::joy_t                    joystick_4,
	output hps_pkg::joy_t                    joystick_5,
	output hps_pkg::status_t                 status,
	input  hps_pkg::status_t                 status_in,
	input  logic                             status_set,
	input  hps_pkg::word_t                   status_menumask,
	output hps_pkg::ps2_key_t                ps2_key,
	output logic                             ioctl_download,
	output logic [7:0]                       ioctl_index,
	output logic                             ioctl_wr,
	output logic [hps_pkg::IOCTL_ADDR_W-1:0] ioctl_addr,
	output logic [7:0]                       ioctl_dout,
	output logic [31:0]                      ioctl_file_ext
);
	import hps_pkg::*;

	word_t cfg;
	joy_t  joystick [NUM_JOY];

	host_frame_if io_frame ();
	host_frame_if fp_frame ();

	//////////////////////////////
	// framers
	//////////////////////////////
	host_frame_decoder frame_io (
		.clk_sys (clk_sys),
		.reset   (reset),
		.enable  (io_enable),
		.strobe  (io_strobe),
		.word    (io_din),
		.frame   (io_frame.framer)
	);

	host_frame_decoder frame_fp (
		.clk_sys (clk_sys),
		.reset   (reset),
		.enable  (fp_enable),
		.strobe  (io_strobe),
		.word    (io_din),
		.frame   (fp_frame.framer)
	);

	//////////////////////////////
	// handlers
	//////////////////////////////
	control_regs control_regs_inst (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.frame           (io_frame.handler),
		.status_in       (status_in),
		.status_set      (status_set),
		.status_menumask (status_menumask),
		.cfg             (cfg),
		.joystick        (joystick),
		.status          (status),
		.io_dout         (io_dout)
	);

	ps2_key_decoder ps2_key_decoder_inst (
		.clk_sys (clk_sys),
		.reset   (reset),
		.frame   (io_frame.handler),
		.ps2_key (ps2_key)
	);

	file_loader file_loader_inst (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.frame          (fp_frame.handler),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_file_ext (ioctl_file_ext)
	);

	// config bits 2, 3 and 5 are used by the system top, not the core
	assign buttons            = cfg[1:0];
	assign forced_scandoubler = cfg[CFG_FORCED_SD_BIT];
	assign direct_video       = cfg[CFG_DIRECT_VIDEO_BIT];

	assign joystick_0 = joystick[0];
	assign joystick_1 = joystick[1];
	assign joystick_2 = joystick[2];
	assign joystick_3 = joystick[3];
	assign joystick_4 = joystick[4];
	assign joystick_5 = joystick[5];

endmodule

// File: testbench/host_bus_tasks.svh
// host bus driver tasks for the bridge testbench
// frame transfer with reply capture, status request pulses and LFSR data
`ifndef HOST_BUS_TASKS_SVH
`define HOST_BUS_TASKS_SVH

// one frame on the chosen enable, rx_words[i] is io_dout just before word i
task automatic send_frame(input bit on_fp, input int count);
	for (int i = 0; i < 5; i++) begin
		rx_words[i] = '0;
	end
	@(posedge clk_sys);
	#DRIVE_DELAY;
	io_enable = ~on_fp;
	fp_enable = on_fp;
	for (int i = 0; i < count; i++) begin
		// idle cycle before every strobe
		@(posedge clk_sys);
		#DRIVE_DELAY;
		rx_words[i] = io_dout;
		io_din      = tx_words[i];
		io_strobe   = 1'b1;
		@(posedge clk_sys);
		#DRIVE_DELAY;
		io_strobe = 1'b0;
	end
	@(posedge clk_sys);
	#DRIVE_DELAY;
	io_enable = 1'b0;
	fp_enable = 1'b0;
	repeat (3) @(posedge clk_sys);
	#DRIVE_DELAY;
endtask

// n rising edges on status_set, each with a fresh status_in
task automatic pulse_status_set(input int n);
	for (int k = 1; k <= n; k++) begin
		@(posedge clk_sys);
		#DRIVE_DELAY;
		status_in      = {16'(k), 16'hC0DE ^ 16'(k), 16'(k * 7), 16'hBEEF};
		status_set     = 1'b1;
		last_status_in = status_in;
		@(posedge clk_sys);
		#DRIVE_DELAY;
		status_set = 1'b0;
	end
	set_count = set_count + n;
endtask

// fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
	return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
endfunction

// one new LFSR bit per data bit
task automatic random_byte(output logic [7:0] value);
	value = '0;
	for (int i = 0; i < 8; i++) begin
		lfsr_state = lfsr_step(lfsr_state);
		value      = {value[6:0], lfsr_state[0]};
	end
endtask

`endif

// File: testbench/tb_hps_io.sv
// testbench for the host command bridge
// drives io and file frames from a table and checks every output path
`timescale 1ns/1ps

module tb_hps_io;
	import hps_pkg::*;

	localparam real        CLK_HALF       = 2.0;
	localparam real        DRIVE_DELAY    = 0.5;
	localparam int         RESET_CYCLES   = 10;
	localparam int         NUM_ROWS       = 19;
	localparam int         SET_PULSES     = 18;
	localparam int         DL_BYTES       = 8;
	localparam int         TIMEOUT_CYCLES = NUM_ROWS * 20 + RESET_CYCLES + SET_PULSES * 2
		+ DL_BYTES * 4;
	localparam word_t      MENUMASK       = 16'h5A3C;
	localparam logic [7:0] DL_INDEX       = 8'h03;
	localparam logic [31:0] DL_EXT        = 32'h2E524F4D;

	// what a row checks after its frame
	localparam int K_CFG = 0, K_JOY = 1, K_STATUS = 2, K_MENU = 3, K_STATREQ = 4;
	localparam int K_KEY = 5, K_NOKEY = 6, K_INDEX = 7, K_EXT = 8, K_START = 9;
	localparam int K_DATA = 10, K_STOP = 11;

	// data words packed, first data word in the low 16 bits
	typedef struct {
		string       name;
		bit          on_fp;
		word_t       cmd;
		logic [63:0] data;
		int          ndata;
		int          kind;
		logic [63:0] expected;
	} row_t;

	logic clk_sys = 1'b0;
	logic reset, io_enable, fp_enable, io_strobe, status_set;
	word_t io_din, io_dout, status_menumask;
	status_t status_in, status;
	logic [1:0] buttons;
	logic forced_scandoubler, direct_video, ioctl_download, ioctl_wr;
	joy_t joy_out [NUM_JOY];
	ps2_key_t ps2_key;
	logic [7:0] ioctl_index, ioctl_dout;
	logic [IOCTL_ADDR_W-1:0] ioctl_addr;
	logic [31:0] ioctl_file_ext;

	row_t rows [NUM_ROWS];
	int row_count = 0;
	int cycles = 0;
	word_t tx_words [5];
	word_t rx_words [5];
	joy_t joy_model [NUM_JOY];
	ps2_key_t key_model;
	bit key_toggle;
	int set_count;
	status_t last_status_in;
	logic [31:0] lfsr_state;
	logic [7:0] dl_bytes [$];
	logic [IOCTL_ADDR_W-1:0] wr_addr_q [$];
	logic [7:0] wr_data_q [$];

	`include "host_bus_tasks.svh"

	hps_io hps_io_inst (
		.clk_sys (clk_sys), .reset (reset),
		.io_enable (io_enable), .fp_enable (fp_enable), .io_strobe (io_strobe),
		.io_din (io_din), .io_dout (io_dout),
		.buttons (buttons), .forced_scandoubler (forced_scandoubler),
		.direct_video (direct_video),
		.joystick_0 (joy_out[0]), .joystick_1 (joy_out[1]), .joystick_2 (joy_out[2]),
		.joystick_3 (joy_out[3]), .joystick_4 (joy_out[4]), .joystick_5 (joy_out[5]),
		.status (status), .status_in (status_in), .status_set (status_set),
		.status_menumask (status_menumask), .ps2_key (ps2_key),
		.ioctl_download (ioctl_download), .ioctl_index (ioctl_index),
		.ioctl_wr (ioctl_wr), .ioctl_addr (ioctl_addr), .ioctl_dout (ioctl_dout),
		.ioctl_file_ext (ioctl_file_ext)
	);

	always #CLK_HALF clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("STATUS: FAIL");
			$fatal(1, "simulation timeout");
		end
	end

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		assert (actual === expected) else begin
			$display("CHECK FAILED: %s expected %0h actual %0h", name, expected, actual);
			$display("STATUS: FAIL");
			$fatal(1, "mismatch in %s", name);
		end
	endtask

	// write pulses are caught mid-cycle where the outputs are settled
	always @(negedge clk_sys) begin
		if (!reset && ioctl_wr) begin
			check_value("download active on write", 64'd1, 64'(ioctl_download));
			wr_addr_q.push_back(ioctl_addr);
			wr_data_q.push_back(ioctl_dout);
		end
	end

	function automatic int joy_slot(input word_t cmd);
		return (cmd < 16'h0010) ? int'(cmd) - 2 : int'(cmd) - 14;
	endfunction

	task automatic add_row(input string name, input bit on_fp, input word_t cmd,
		input logic [63:0] data, input int ndata, input int kind, input logic [63:0] expected);
		rows[row_count] = '{name, on_fp, cmd, data, ndata, kind, expected};
		row_count++;
	endtask

	////////////////////////////////
	// stimulus table
	////////////////////////////////
	task automatic build_table();
		// cfg expectation is {direct_video, forced_scandoubler, buttons}
		add_row("cfg_a", 1'b0, CMD_CFG, 64'h0412, 1, K_CFG, 64'hE);
		add_row("joy0", 1'b0, CMD_JOY0, 64'h5678_1234, 2, K_JOY, 64'h5678_1234);
		add_row("joy3", 1'b0, CMD_JOY3, 64'h0F0F_ABCD, 2, K_JOY, 64'h0F0F_ABCD);
		add_row("joy5", 1'b0, CMD_JOY5, 64'h8000_0001, 2, K_JOY, 64'h8000_0001);
		add_row("cfg_b", 1'b0, CMD_CFG, 64'h0011, 1, K_CFG, 64'h5);
		add_row("status", 1'b0, CMD_STATUS, 64'h4444_3333_2222_1111, 4, K_STATUS,
			64'h4444_3333_2222_1111);
		add_row("menumask", 1'b0, CMD_MENUMASK, 64'h0, 1, K_MENU, 64'(MENUMASK));
		add_row("status_req", 1'b0, CMD_STATUS_REQ, 64'h0, 4, K_STATREQ, 64'h0);
		// key expectation is {pressed, extended, code}
		add_row("key_make", 1'b0, CMD_KBD, 64'h001C, 1, K_KEY, 64'h21C);
		add_row("key_break", 1'b0, CMD_KBD, 64'h001C_00F0, 2, K_KEY, 64'h01C);
		add_row("key_ext_break", 1'b0, CMD_KBD, 64'h0075_00F0_00E0, 3, K_KEY, 64'h175);
		add_row("key_skip", 1'b0, CMD_KBD, 64'hFF1C, 1, K_NOKEY, 64'h0);
		add_row("key_prnscr", 1'b0, CMD_KBD, 64'h007C_00E0_0012_00E0, 4, K_KEY, 64'h37C);
		add_row("dl_index", 1'b1, CMD_FILE_INDEX, 64'(DL_INDEX), 1, K_INDEX, 64'(DL_INDEX));
		add_row("dl_ext", 1'b1, CMD_FILE_INFO, 64'({DL_EXT[15:0], DL_EXT[31:16]}), 2, K_EXT,
			64'(DL_EXT));
		add_row("dl_start", 1'b1, CMD_FILE_TX, 64'h0001, 1, K_START, 64'h1);
		add_row("dl_data_a", 1'b1, CMD_FILE_DAT, 64'h0, 4, K_DATA, 64'h0);
		add_row("dl_data_b", 1'b1, CMD_FILE_DAT, 64'h0, 4, K_DATA, 64'h0);
		add_row("dl_stop", 1'b1, CMD_FILE_TX, 64'h0, 1, K_STOP, 64'(DL_BYTES));
	endtask

	task automatic apply_row(input int r);
		logic [7:0] b;
		tx_words[0] = rows[r].cmd;
		for (int i = 0; i < 4; i++) begin
			tx_words[i + 1] = rows[r].data[16 * i +: 16];
		end
		if (rows[r].kind == K_DATA) begin
			for (int i = 1; i <= rows[r].ndata; i++) begin
				random_byte(b);
				tx_words[i] = {8'h00, b};
				dl_bytes.push_back(b);
			end
		end
		if (rows[r].kind == K_STATREQ) begin
			pulse_status_set(SET_PULSES);
		end
		send_frame(rows[r].on_fp, rows[r].ndata + 1);

		case (rows[r].kind)
			K_CFG: check_value(rows[r].name, rows[r].expected,
				64'({direct_video, forced_scandoubler, buttons}));
			K_JOY: begin
				joy_model[joy_slot(rows[r].cmd)] = rows[r].expected[31:0];
				for (int j = 0; j < NUM_JOY; j++) begin
					check_value(rows[r].name, 64'(joy_model[j]), 64'(joy_out[j]));
				end
			end
			K_STATUS: check_value(rows[r].name, rows[r].expected, status);
			K_MENU: check_value(rows[r].name, rows[r].expected, 64'(rx_words[1]));
			K_STATREQ: begin
				// tag 0xA in bits 7..4, request count in bits 3..0
				check_value(rows[r].name, 64'(16'h00A0 | 16'(set_count % 16)),
					64'(rx_words[1]));
				for (int q = 1; q <= 3; q++) begin
					check_value(rows[r].name, 64'(last_status_in[16 * q +: 16]),
						64'(rx_words[q + 1]));
				end
			end
			K_KEY, K_NOKEY: begin
				if (rows[r].kind == K_KEY) begin
					key_toggle = ~key_toggle;
					key_model  = {key_toggle, rows[r].expected[9:0]};
				end
				check_value(rows[r].name, 64'(key_model), 64'(ps2_key));
			end
			K_INDEX: check_value(rows[r].name, rows[r].expected, 64'(ioctl_index));
			K_EXT: check_value(rows[r].name, rows[r].expected, 64'(ioctl_file_ext));
			K_START: check_value(rows[r].name, rows[r].expected, 64'(ioctl_download));
			K_STOP: begin
				check_value(rows[r].name, 64'd0, 64'(ioctl_download));
				check_value(rows[r].name, rows[r].expected, 64'(ioctl_addr));
				check_value("write count", 64'(DL_BYTES), 64'(wr_addr_q.size()));
				for (int i = 0; i < DL_BYTES; i++) begin
					check_value("write address", 64'(i), 64'(wr_addr_q[i]));
					check_value("write data", 64'(dl_bytes[i]), 64'(wr_data_q[i]));
				end
			end
			default: ;
		endcase
	endtask

	////////////////////////////////
	// main sequence
	////////////////////////////////
	initial begin
		reset           = 1'b1;
		io_enable       = 1'b0;
		fp_enable       = 1'b0;
		io_strobe       = 1'b0;
		io_din          = '0;
		status_in       = '0;
		status_set      = 1'b0;
		status_menumask = MENUMASK;
		lfsr_state      = 32'd93205;
		key_toggle      = 1'b0;
		key_model       = '0;
		set_count       = 0;
		last_status_in  = '0;
		for (int j = 0; j < NUM_JOY; j++) begin
			joy_model[j] = '0;
		end
		build_table();

		repeat (RESET_CYCLES) @(posedge clk_sys);
		#DRIVE_DELAY;
		reset = 1'b0;
		@(posedge clk_sys);
		#DRIVE_DELAY;

		// everything starts cleared
		check_value("reset io_dout", 64'd0, 64'(io_dout));
		check_value("reset cfg", 64'd0, 64'({direct_video, forced_scandoubler, buttons}));
		check_value("reset joy 0-1", 64'd0, {joy_out[1], joy_out[0]});
		check_value("reset joy 2-3", 64'd0, {joy_out[3], joy_out[2]});
		check_value("reset joy 4-5", 64'd0, {joy_out[5], joy_out[4]});
		check_value("reset status", 64'd0, status);
		check_value("reset ps2_key", 64'd0, 64'(ps2_key));
		check_value("reset ioctl", 64'd0,
			64'({ioctl_download, ioctl_wr, ioctl_index, ioctl_dout}));
		check_value("reset ioctl_addr", 64'd0, 64'(ioctl_addr));
		check_value("reset ioctl_file_ext", 64'd0, 64'(ioctl_file_ext));

		for (int r = 0; r < row_count; r++) begin
			apply_row(r);
		end

		check_value("final ioctl_index", 64'(DL_INDEX), 64'(ioctl_index));
		check_value("final ioctl_file_ext", 64'(DL_EXT), 64'(ioctl_file_ext));
		$display("STATUS: PASS");
		$finish;
	end

endmodule

// File: project.f
+incdir+testbench
design/hps_pkg.sv
design/host_frame_if.sv
design/host_frame_decoder.sv
design/control_regs.sv
design/ps2_key_decoder.sv
design/file_loader.sv
design/hps_io.sv
testbench/tb_hps_io.sv

// File: Makefile
# Verilator build for the host command bridge testbench
# usage: make compile | make run | make clean

VERILATOR ?= verilator
TOP       ?= tb_hps_io
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= STATUS: PASS

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# the run passes only if the pass line shows up in the simulator output
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
